// ==== all.f ====
hw/trig_pkg.sv
hw/axil_reg_port.sv
hw/trig_regs.sv
hw/trig_channel.sv
hw/trig_unit.sv
verification/trig_chk.sv
verification/trig_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= trig_tb
FILE_LIST ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT := *** PASSED ***

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	$(SIM_BIN) $(SIM_ARGS) | tee $(LOG)
	grep -q -F '$(PASS_TEXT)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/trig_tb.sv ====
module trig_tb;

  import trig_pkg::*;

  localparam int unsigned N_TRIGGER  = 8;
  localparam int unsigned WAIT_LIMIT = 50;

  logic                  axilite;
  logic                  rstn;
  logic                  awvalid;
  logic                  awready;
  logic [ADDR_WIDTH-1:0] awaddr;
  logic                  wvalid;
  logic                  wready;
  logic [DATA_WIDTH-1:0] wdata;
  logic                  bvalid;
  logic                  bready;
  logic [1:0]            bresp;
  logic                  arvalid;
  logic                  arready;
  logic [ADDR_WIDTH-1:0] araddr;
  logic                  rvalid;
  logic                  rready;
  logic [DATA_WIDTH-1:0] rdata;
  logic [1:0]            rresp;
  logic [N_TRIGGER-1:0]  triggers;

  logic [31:0]           rng_state;
  logic [DATA_WIDTH-1:0] rd_word;

  trig_unit #(
    .N_TRIGGER(N_TRIGGER)
  ) i_dut (.*);

  initial begin
    axilite = 1'b0;
    forever #50 axilite = ~axilite;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [ADDR_WIDTH-1:0] byte_addr(input logic [REG_ADDR_BITS-1:0] index);
    return {index, 2'b00};
  endfunction

  task automatic stop_with_failure(input string reason);
    $display("*** FAILED ***");
    $fatal(1, "%s", reason);
  endtask

  // Inputs move 10 units after the rising edge.
  task automatic next_cycle();
    @(posedge axilite);
    #10;
  endtask

  task automatic random_stall();
    int unsigned cycles;
    rng_state = xorshift(rng_state);
    cycles = rng_state[1:0];
    repeat (cycles) next_cycle();
  endtask

  task automatic bus_write(input logic [REG_ADDR_BITS-1:0] index, input logic [31:0] data);
    int unsigned waited;
    awvalid = 1'b1;
    awaddr  = byte_addr(index);
    wvalid  = 1'b1;
    wdata   = data;
    waited  = 0;
    while (!(awready && wready)) begin
      next_cycle();
      waited++;
      if (waited > WAIT_LIMIT) stop_with_failure("Timed out waiting for awready and wready.");
    end
    next_cycle(); // Address and data are taken at this edge.
    awvalid = 1'b0;
    wvalid  = 1'b0;
    random_stall();
    bready = 1'b1;
    waited = 0;
    while (!bvalid) begin
      next_cycle();
      waited++;
      if (waited > WAIT_LIMIT) stop_with_failure("Timed out waiting for bvalid.");
    end
    next_cycle();
    bready = 1'b0;
  endtask

  task automatic bus_read(input logic [REG_ADDR_BITS-1:0] index,
                          output logic [DATA_WIDTH-1:0] data);
    int unsigned waited;
    arvalid = 1'b1;
    araddr  = byte_addr(index);
    waited  = 0;
    while (!arready) begin
      next_cycle();
      waited++;
      if (waited > WAIT_LIMIT) stop_with_failure("Timed out waiting for arready.");
    end
    next_cycle();
    arvalid = 1'b0;
    random_stall();
    rready = 1'b1;
    waited = 0;
    while (!rvalid) begin
      next_cycle();
      waited++;
      if (waited > WAIT_LIMIT) stop_with_failure("Timed out waiting for rvalid.");
    end
    data = rdata;
    next_cycle();
    rready = 1'b0;
  endtask

  // Polls the trigger register until no channel is armed.
  task automatic wait_all_disarmed();
    int unsigned tries;
    logic [DATA_WIDTH-1:0] status;
    tries = 0;
    bus_read(REG_TRIGGER, status);
    while (status != '0) begin
      tries++;
      if (tries > WAIT_LIMIT) stop_with_failure("Channels stayed armed far too long.");
      bus_read(REG_TRIGGER, status);
    end
  endtask

  always @(negedge axilite) begin
    if (i_dut.i_chk.fail_count != 0) begin
      stop_with_failure("The checker reported an assertion failure.");
    end
  end

  initial begin
    logic [31:0] delays [N_TRIGGER];
    rng_state = 32'he414;
    rstn      = 1'b0;
    awvalid   = 1'b0;
    awaddr    = '0;
    wvalid    = 1'b0;
    wdata     = '0;
    bready    = 1'b0;
    arvalid   = 1'b0;
    araddr    = '0;
    rready    = 1'b0;
    repeat (3) @(posedge axilite);
    #10;
    rstn = 1'b1;

    bus_read(REG_ID, rd_word);
    bus_read(REG_MASK, rd_word);
    bus_read(REG_ADDR_BITS'(REG_DELAY_BASE + N_TRIGGER), rd_word);
    bus_read('1, rd_word);

    // Channel 0 fires with no wait, the others all differ.
    delays = '{32'd0, 32'd3, 32'd7, 32'd1, 32'd12, 32'd5, 32'd20, 32'd9};
    for (int i = 0; i < N_TRIGGER; i++) begin
      bus_write(REG_ADDR_BITS'(REG_DELAY_BASE + i), delays[i]);
    end
    for (int i = 0; i < N_TRIGGER; i++) begin
      bus_read(REG_ADDR_BITS'(REG_DELAY_BASE + i), rd_word);
    end
    bus_write(REG_MASK, 32'h0000_00B7); // Channels 3 and 6 stay silent.
    bus_read(REG_MASK, rd_word);
    bus_write(REG_TRIGGER, 32'h0);
    bus_read(REG_TRIGGER, rd_word);
    wait_all_disarmed();

    // The second trigger lands while the long waits are still pending.
    bus_write(REG_MASK, 32'h0000_00FF);
    bus_write(REG_ADDR_BITS'(REG_DELAY_BASE + 2), 32'd25);
    bus_write(REG_ADDR_BITS'(REG_DELAY_BASE + 5), 32'd40);
    bus_write(REG_TRIGGER, 32'h0);
    bus_write(REG_TRIGGER, 32'h0);
    bus_read(REG_TRIGGER, rd_word);
    wait_all_disarmed();

    repeat (4) begin
      for (int i = 0; i < N_TRIGGER; i++) begin
        rng_state = xorshift(rng_state);
        bus_write(REG_ADDR_BITS'(REG_DELAY_BASE + i), 32'(rng_state[4:0]));
      end
      rng_state = xorshift(rng_state);
      bus_write(REG_MASK, 32'(rng_state[N_TRIGGER-1:0]));
      bus_write(REG_TRIGGER, rng_state);
      bus_read(REG_TRIGGER, rd_word);
      wait_all_disarmed();
    end

    repeat (3) next_cycle();
    if (i_dut.i_chk.fail_count == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      stop_with_failure("The checker reported an assertion failure.");
    end
  end

endmodule

// ==== verification/trig_chk.sv ====
module trig_chk #(
  parameter int unsigned N_TRIGGER = 8
) (
  input logic                            axilite,
  input logic                            rstn,
  input logic                            awvalid,
  input logic                            awready,
  input logic [trig_pkg::ADDR_WIDTH-1:0] awaddr,
  input logic                            wvalid,
  input logic                            wready,
  input logic [trig_pkg::DATA_WIDTH-1:0] wdata,
  input logic                            bvalid,
  input logic                            bready,
  input logic [1:0]                      bresp,
  input logic                            arvalid,
  input logic                            arready,
  input logic [trig_pkg::ADDR_WIDTH-1:0] araddr,
  input logic                            rvalid,
  input logic                            rready,
  input logic [trig_pkg::DATA_WIDTH-1:0] rdata,
  input logic [1:0]                      rresp,
  input logic [N_TRIGGER-1:0]            triggers
);

  import trig_pkg::*;

  int unsigned fail_count = 0;

  logic                     pend_wr;
  logic [REG_ADDR_BITS-1:0] pend_index;
  logic [DATA_WIDTH-1:0]    pend_data;
  logic                     arm_due;
  logic [N_TRIGGER-1:0]     model_mask;
  logic [DATA_WIDTH-1:0]    model_delay [N_TRIGGER];
  logic [DATA_WIDTH:0]      due [N_TRIGGER]; // Edges left until the channel fires, zero when idle.
  logic [N_TRIGGER-1:0]     model_armed;
  logic [N_TRIGGER-1:0]     exp_fire;
  logic [DATA_WIDTH-1:0]    exp_rdata;

  always_comb begin
    for (int i = 0; i < N_TRIGGER; i++) begin
      model_armed[i] = due[i] != '0;
    end
  end

  function automatic logic [DATA_WIDTH-1:0] read_value(input logic [REG_ADDR_BITS-1:0] index);
    logic [DATA_WIDTH-1:0] value;
    value = UNMAPPED_VALUE;
    if (index == REG_ID) begin
      value = ID_VALUE;
    end else if (index == REG_MASK) begin
      value = DATA_WIDTH'(model_mask);
    end else if (index == REG_TRIGGER) begin
      value = DATA_WIDTH'(model_armed);
    end else begin
      for (int i = 0; i < N_TRIGGER; i++) begin
        if (index == REG_ADDR_BITS'(REG_DELAY_BASE + i)) begin
          value = model_delay[i];
        end
      end
    end
    return value;
  endfunction

  // The model follows the bus handshakes only. A write lands one edge after it is taken.
  always_ff @(posedge axilite) begin
    if (!rstn) begin
      pend_wr    <= 1'b0;
      arm_due    <= 1'b0;
      model_mask <= '1;
      exp_fire   <= '0;
      for (int i = 0; i < N_TRIGGER; i++) begin
        model_delay[i] <= '0;
        due[i]         <= '0;
      end
    end else begin
      pend_wr    <= awvalid && awready && wvalid && wready;
      pend_index <= awaddr[ADDR_WIDTH-1:2];
      pend_data  <= wdata;
      arm_due    <= pend_wr && pend_index == REG_TRIGGER; // Reaches the channels one edge later.
      if (pend_wr && pend_index == REG_MASK) begin
        model_mask <= pend_data[N_TRIGGER-1:0];
      end
      for (int i = 0; i < N_TRIGGER; i++) begin
        if (pend_wr && pend_index == REG_ADDR_BITS'(REG_DELAY_BASE + i)) begin
          model_delay[i] <= pend_data;
        end
        exp_fire[i] <= 1'b0;
        if (arm_due) begin
          exp_fire[i] <= model_armed[i]; // A pending shot goes out right away.
          due[i]      <= {1'b0, model_delay[i]} + 1'b1;
        end else if (due[i] == 1) begin
          exp_fire[i] <= 1'b1;
          due[i]      <= '0;
        end else if (due[i] != '0) begin
          due[i] <= due[i] - 1'b1;
        end
      end
      if (arvalid && arready) begin
        exp_rdata <= read_value(araddr[ADDR_WIDTH-1:2]);
      end
    end
  end

  a_bvalid_hold: assert property (@(posedge axilite) disable iff (!rstn)
      bvalid && !bready |=> bvalid)
    else begin
      fail_count++;
      $error("bvalid dropped before the write response was taken.");
    end

  a_rvalid_hold: assert property (@(posedge axilite) disable iff (!rstn)
      rvalid && !rready |=> rvalid && $stable(rdata))
    else begin
      fail_count++;
      $error("rvalid dropped or rdata changed before the read response was taken.");
    end

  a_bresp: assert property (@(posedge axilite) disable iff (!rstn)
      bvalid |-> bresp == RESP_OKAY)
    else begin
      fail_count++;
      $error("Error at %0t: bresp expected %0h, got %0h", $time, RESP_OKAY, $sampled(bresp));
    end

  a_rresp: assert property (@(posedge axilite) disable iff (!rstn)
      rvalid |-> rresp == RESP_OKAY)
    else begin
      fail_count++;
      $error("Error at %0t: rresp expected %0h, got %0h", $time, RESP_OKAY, $sampled(rresp));
    end

  a_aw_ready: assert property (@(posedge axilite) disable iff (!rstn)
      awready |-> $past(awvalid && wvalid) && wready)
    else begin
      fail_count++;
      $error("awready and wready rose without a valid write in the cycle before.");
    end

  a_ar_ready: assert property (@(posedge axilite) disable iff (!rstn)
      arready |-> $past(arvalid))
    else begin
      fail_count++;
      $error("arready rose without arvalid in the cycle before.");
    end

  a_rdata: assert property (@(posedge axilite) disable iff (!rstn)
      rvalid |-> rdata == exp_rdata)
    else begin
      fail_count++;
      $error("Error at %0t: rdata expected %h, got %h",
             $time, $sampled(exp_rdata), $sampled(rdata));
    end

  a_masked: assert property (@(posedge axilite) disable iff (!rstn)
      (triggers & ~model_mask) == '0)
    else begin
      fail_count++;
      $error("A masked channel pulsed on triggers.");
    end

  a_triggers: assert property (@(posedge axilite) disable iff (!rstn)
      triggers == (exp_fire & model_mask))
    else begin
      fail_count++;
      $error("Error at %0t: triggers expected %h, got %h",
             $time, $sampled(exp_fire & model_mask), $sampled(triggers));
    end

endmodule

bind trig_unit trig_chk #(
  .N_TRIGGER(N_TRIGGER)
) i_chk (.*);

// ==== hw/trig_unit.sv ====
module trig_unit #(
  parameter int unsigned N_TRIGGER = 8
) (
  input  logic                            axilite,
  input  logic                            rstn,

  input  logic                            awvalid,
  output logic                            awready,
  input  logic [trig_pkg::ADDR_WIDTH-1:0] awaddr,
  input  logic                            wvalid,
  output logic                            wready,
  input  logic [trig_pkg::DATA_WIDTH-1:0] wdata,
  output logic                            bvalid,
  input  logic                            bready,
  output logic [1:0]                      bresp,
  input  logic                            arvalid,
  output logic                            arready,
  input  logic [trig_pkg::ADDR_WIDTH-1:0] araddr,
  output logic                            rvalid,
  input  logic                            rready,
  output logic [trig_pkg::DATA_WIDTH-1:0] rdata,
  output logic [1:0]                      rresp,

  output logic [N_TRIGGER-1:0]            triggers
);

  import trig_pkg::*;

  logic                            wr_en;
  logic [REG_ADDR_BITS-1:0]        wr_index;
  logic [DATA_WIDTH-1:0]           wr_data;
  logic [REG_ADDR_BITS-1:0]        rd_index;
  logic [DATA_WIDTH-1:0]           rd_data;
  logic                            arm;
  logic [N_TRIGGER-1:0]            mask;
  logic [N_TRIGGER*DATA_WIDTH-1:0] delay_flat;
  logic [N_TRIGGER-1:0]            armed;
  logic [N_TRIGGER-1:0]            fire;

  axil_reg_port i_port (.*);

  trig_regs #(
    .N_TRIGGER(N_TRIGGER)
  ) i_regs (.*);

  for (genvar i = 0; i < N_TRIGGER; i++) begin : g_channel
    trig_channel i_channel (
      .axilite    (axilite),
      .rstn       (rstn),
      .arm        (arm),
      .wait_cycles(delay_flat[i*DATA_WIDTH +: DATA_WIDTH]),
      .armed      (armed[i]),
      .fire       (fire[i])
    );
  end

  assign triggers = fire & mask; // Masked channels still run, they just stay silent.

endmodule

// ==== hw/trig_channel.sv ====
module trig_channel (
  input  logic                            axilite,
  input  logic                            rstn,
  input  logic                            arm,
  input  logic [trig_pkg::DATA_WIDTH-1:0] wait_cycles,
  output logic                            armed,
  output logic                            fire
);

  import trig_pkg::*;

  logic [DATA_WIDTH-1:0] count;

  always_ff @(posedge axilite) begin
    if (!rstn) begin
      armed <= 1'b0;
      fire  <= 1'b0;
    end else begin
      fire <= 1'b0;
      if (armed) begin
        if (arm) begin
          // Re-arm fires the pending pulse now and restarts the wait.
          fire  <= 1'b1;
          count <= wait_cycles;
        end else if (count != '0) begin
          count <= count - 1'b1;
        end else begin
          fire  <= 1'b1;
          armed <= 1'b0;
        end
      end else if (arm) begin
        armed <= 1'b1;
        count <= wait_cycles;
      end
    end
  end

endmodule

// ==== hw/trig_regs.sv ====
module trig_regs #(
  parameter int unsigned N_TRIGGER = 8
) (
  input  logic                                       axilite,
  input  logic                                       rstn,

  input  logic                                       wr_en,
  input  logic [trig_pkg::REG_ADDR_BITS-1:0]         wr_index,
  input  logic [trig_pkg::DATA_WIDTH-1:0]            wr_data,
  input  logic [trig_pkg::REG_ADDR_BITS-1:0]         rd_index,
  output logic [trig_pkg::DATA_WIDTH-1:0]            rd_data,

  input  logic [N_TRIGGER-1:0]                       armed,
  output logic                                       arm,
  output logic [N_TRIGGER-1:0]                       mask,
  output logic [N_TRIGGER*trig_pkg::DATA_WIDTH-1:0]  delay_flat
);

  import trig_pkg::*;

  logic [DATA_WIDTH-1:0] delay_q [N_TRIGGER];

  // Mask register, all channels enabled out of reset.
  always_ff @(posedge axilite) begin
    if (!rstn) begin
      mask <= '1;
    end else if (wr_en && wr_index == REG_MASK) begin
      mask <= wr_data[N_TRIGGER-1:0];
    end
  end

  // Any write to the trigger register arms all channels. Its data is ignored.
  always_ff @(posedge axilite) begin
    if (!rstn) begin
      arm <= 1'b0;
    end else begin
      arm <= wr_en && wr_index == REG_TRIGGER;
    end
  end

  always_ff @(posedge axilite) begin
    if (!rstn) begin
      for (int i = 0; i < N_TRIGGER; i++) begin
        delay_q[i] <= '0;
      end
    end else if (wr_en) begin
      for (int i = 0; i < N_TRIGGER; i++) begin
        if (wr_index == REG_ADDR_BITS'(REG_DELAY_BASE + i)) begin
          delay_q[i] <= wr_data;
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < N_TRIGGER; i++) begin
      delay_flat[i*DATA_WIDTH +: DATA_WIDTH] = delay_q[i];
    end
  end

  // Read lookup, combinational in the index.
  always_comb begin
    case (rd_index)
      REG_ID: begin
        rd_data = ID_VALUE;
      end
      REG_MASK: begin
        rd_data = DATA_WIDTH'(mask);
      end
      REG_TRIGGER: begin
        rd_data = DATA_WIDTH'(armed); // Upper bits read as zero.
      end
      default: begin
        rd_data = UNMAPPED_VALUE;
        for (int i = 0; i < N_TRIGGER; i++) begin
          if (rd_index == REG_ADDR_BITS'(REG_DELAY_BASE + i)) begin
            rd_data = delay_q[i];
          end
        end
      end
    endcase
  end

endmodule

// ==== hw/axil_reg_port.sv ====
module axil_reg_port (
  input  logic                               axilite,
  input  logic                               rstn,

  input  logic                               awvalid,
  output logic                               awready,
  input  logic [trig_pkg::ADDR_WIDTH-1:0]    awaddr,

  input  logic                               wvalid,
  output logic                               wready,
  input  logic [trig_pkg::DATA_WIDTH-1:0]    wdata,

  output logic                               bvalid,
  input  logic                               bready,
  output logic [1:0]                         bresp,

  input  logic                               arvalid,
  output logic                               arready,
  input  logic [trig_pkg::ADDR_WIDTH-1:0]    araddr,

  output logic                               rvalid,
  input  logic                               rready,
  output logic [trig_pkg::DATA_WIDTH-1:0]    rdata,
  output logic [1:0]                         rresp,

  output logic                               wr_en,
  output logic [trig_pkg::REG_ADDR_BITS-1:0] wr_index,
  output logic [trig_pkg::DATA_WIDTH-1:0]    wr_data,
  output logic [trig_pkg::REG_ADDR_BITS-1:0] rd_index,
  input  logic [trig_pkg::DATA_WIDTH-1:0]    rd_data
);

  import trig_pkg::*;

  logic wr_accept;
  logic rd_accept;

  // A new write needs both channels valid and no response still waiting.
  assign wr_accept = awvalid && wvalid && !bvalid && !awready;
  assign rd_accept = arvalid && !rvalid && !arready;

  assign bresp = RESP_OKAY;
  assign rresp = RESP_OKAY;

  // Write path.
  always_ff @(posedge axilite) begin
    if (!rstn) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      wr_en   <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      awready <= wr_accept;
      wready  <= wr_accept;
      wr_en   <= awready; // The handshake completes at the end of the ready cycle.
      if (awready) begin
        bvalid <= 1'b1;
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  // Address and data are stable while the ready cycle lasts.
  always_ff @(posedge axilite) begin
    if (awready) begin
      wr_index <= awaddr[ADDR_WIDTH-1:2];
      wr_data  <= wdata;
    end
  end

  // Read path.
  always_ff @(posedge axilite) begin
    if (!rstn) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= rd_accept;
      if (arready) begin
        rvalid <= 1'b1;
      end else if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // The index is latched on accept so the lookup settles during the ready cycle.
  always_ff @(posedge axilite) begin
    if (rd_accept) begin
      rd_index <= araddr[ADDR_WIDTH-1:2];
    end
    if (arready) begin
      rdata <= rd_data; // Held until the manager takes it.
    end
  end

endmodule

// ==== hw/trig_pkg.sv ====
package trig_pkg;

  // Bus word width. The channel counters use the same width.
  localparam int unsigned DATA_WIDTH = 32;

  // Byte address on the AXI4-Lite bus.
  localparam int unsigned ADDR_WIDTH = 12;

  // Word index width, with the two byte-offset bits dropped.
  localparam int unsigned REG_ADDR_BITS = ADDR_WIDTH - 2;

  // Register map as word indices.
  localparam logic [REG_ADDR_BITS-1:0] REG_ID         = REG_ADDR_BITS'(0);
  localparam logic [REG_ADDR_BITS-1:0] REG_MASK       = REG_ADDR_BITS'(1);
  localparam logic [REG_ADDR_BITS-1:0] REG_TRIGGER    = REG_ADDR_BITS'(2);
  localparam logic [REG_ADDR_BITS-1:0] REG_DELAY_BASE = REG_ADDR_BITS'(3);

  // "PTRG" in ASCII, so software can identify the block.
  localparam logic [DATA_WIDTH-1:0] ID_VALUE = 32'h5054_5247;

  // Read back from any index without a register ("PRDO").
  localparam logic [DATA_WIDTH-1:0] UNMAPPED_VALUE = 32'h5052_444F;

  // Every response is OKAY.
  localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage
